//--- verilog/cache_pkg.sv
package cache_pkg;

    // ----------------------------------------------------------------------
    // Geometry of the cache. The top level may override these values.
    // ----------------------------------------------------------------------
    localparam int NUM_WAY   = 4;
    localparam int NUM_SET   = 16;
    localparam int TAG_WIDTH = 8;

    typedef logic [NUM_WAY - 1 : 0]         way_vec_t;   // One bit per way.
    typedef logic [$clog2(NUM_SET) - 1 : 0] set_addr_t;
    typedef logic [TAG_WIDTH - 1 : 0]       tag_t;

    typedef struct packed
    {
        set_addr_t set;
        tag_t      tag;
    } access_req_t;

    typedef struct packed
    {
        logic     hit;
        way_vec_t way;                                    // One-hot.
    } access_result_t;

    // One entry of the tag array holds a whole set.
    typedef struct packed
    {
        way_vec_t                   valid;
        tag_t [NUM_WAY - 1 : 0]     tags;
    } tag_line_t;

endpackage

//--- verilog/find_first_one_index.sv
module find_first_one_index
#(
    parameter int VECTOR_LENGTH = 4
)
(
    input  logic [VECTOR_LENGTH - 1 : 0] vector,
    output logic [VECTOR_LENGTH - 1 : 0] first_one,
    output logic                         one_is_found
);

    logic [VECTOR_LENGTH - 1 : 0] seen_below;   // Bit i is set if a lower bit is set.

    // Ripple a "seen" flag upward so only the lowest set bit survives.
    always_comb
    begin
        seen_below[0] = 1'b0;
        for (int i = 1; i < VECTOR_LENGTH; i++)
        begin
            seen_below[i] = seen_below[i - 1] | vector[i - 1];
        end
    end

    assign first_one    = vector & ~seen_below;
    assign one_is_found = |vector;

endmodule

//--- verilog/dual_port_lutram.sv
module dual_port_lutram
    import cache_pkg::*;
#(
    parameter type entry_t = logic,
    parameter int  NUM_SET = cache_pkg::NUM_SET
)
(
    input  logic      clk_in,
    input  logic      reset_in,

    input  logic      write_en,
    input  set_addr_t write_set_addr,
    input  entry_t    write_data,

    input  logic      read_en,
    input  set_addr_t read_set_addr,
    output entry_t    read_data
);

    entry_t mem [NUM_SET];

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            for (int i = 0; i < NUM_SET; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (write_en)
        begin
            mem[write_set_addr] <= write_data;
        end
    end

    // Registered read. A write to the same set on the same edge is forwarded,
    // so the reader sees the new entry.
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            read_data <= '0;
        end
        else if (read_en)
        begin
            if (write_en && (write_set_addr == read_set_addr))
            begin
                read_data <= write_data;
            end
            else
            begin
                read_data <= mem[read_set_addr];
            end
        end
    end

endmodule

//--- verilog/tag_lookup.sv
module tag_lookup
    import cache_pkg::*;
#(
    parameter int NUM_WAY   = cache_pkg::NUM_WAY,
    parameter int NUM_SET   = cache_pkg::NUM_SET,
    parameter int TAG_WIDTH = cache_pkg::TAG_WIDTH
)
(
    input  logic           clk_in,
    input  logic           reset_in,

    input  logic           access_valid,
    input  access_req_t    access,

    input  way_vec_t       victim_way,
    output way_vec_t       valid_ways,
    output way_vec_t       used_way,
    output logic           stage_valid,
    output set_addr_t      stage_set,

    output logic           result_valid,
    output access_result_t result
);

    access_req_t stage_req;
    tag_line_t   read_line;
    tag_line_t   fill_line;
    way_vec_t    hit_way;
    logic        hit;
    logic        fill_en;

    if (TAG_WIDTH != $bits(tag_t))
    begin : g_tag_width_check
        $error("TAG_WIDTH does not match the width of tag_t.");
    end

    // ----------------------------------------------------------------------
    // Stage register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            stage_valid <= 1'b0;
        end
        else
        begin
            stage_valid <= access_valid;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (access_valid)
        begin
            stage_req <= access;
        end
    end

    assign stage_set = stage_req.set;

    // ----------------------------------------------------------------------
    // Compare and fill
    // ----------------------------------------------------------------------
    always_comb
    begin
        for (int way = 0; way < NUM_WAY; way++)
        begin
            hit_way[way] = read_line.valid[way] && (read_line.tags[way] == stage_req.tag);
        end
    end

    assign hit = |hit_way;                     // Tags in a set are unique, so at most one.

    always_comb
    begin
        fill_line.valid = read_line.valid | victim_way;
        for (int way = 0; way < NUM_WAY; way++)
        begin
            fill_line.tags[way] = victim_way[way] ? stage_req.tag : read_line.tags[way];
        end
    end

    assign fill_en    = stage_valid && !hit;
    assign valid_ways = read_line.valid;
    assign used_way   = hit ? hit_way : victim_way;

    assign result_valid = stage_valid;
    assign result       = '{hit: hit, way: used_way};

    dual_port_lutram
    #(
        .entry_t        (tag_line_t),
        .NUM_SET        (NUM_SET)
    )
    i_tag_array
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .write_en       (fill_en),
        .write_set_addr (stage_req.set),
        .write_data     (fill_line),
        .read_en        (access_valid),
        .read_set_addr  (access.set),
        .read_data      (read_line)
    );

endmodule

//--- verilog/replacer.sv
module replacer
    import cache_pkg::*;
#(
    parameter int NUM_WAY = cache_pkg::NUM_WAY,
    parameter int NUM_SET = cache_pkg::NUM_SET
)
(
    input  logic      clk_in,
    input  logic      reset_in,

    input  logic      read_en,
    input  set_addr_t read_set_addr,

    input  logic      write_en,
    input  set_addr_t write_set_addr,

    input  way_vec_t  valid_ways,
    input  way_vec_t  used_way,
    output way_vec_t  victim_way
);

    way_vec_t read_history;
    way_vec_t merged_history;
    way_vec_t write_history;
    way_vec_t first_invalid;
    way_vec_t first_unused;
    logic     invalid_found;
    logic     unused_found;

    // ----------------------------------------------------------------------
    // Victim selection
    // ----------------------------------------------------------------------
    find_first_one_index
    #(
        .VECTOR_LENGTH (NUM_WAY)
    )
    i_first_invalid
    (
        .vector        (~valid_ways),
        .first_one     (first_invalid),
        .one_is_found  (invalid_found)
    );

    find_first_one_index
    #(
        .VECTOR_LENGTH (NUM_WAY)
    )
    i_first_unused
    (
        .vector        (~read_history),
        .first_one     (first_unused),
        .one_is_found  (unused_found)
    );

    always_comb
    begin
        if (invalid_found)
        begin
            victim_way = first_invalid;            // Empty ways are filled first.
        end
        else if (unused_found)
        begin
            victim_way = first_unused;
        end
        else
        begin
            victim_way = way_vec_t'(1);
        end
    end

    // ----------------------------------------------------------------------
    // NRU history update
    // ----------------------------------------------------------------------
    assign merged_history = read_history | used_way;
    assign write_history  = (&merged_history) ? used_way : merged_history;   // Age the set.

    dual_port_lutram
    #(
        .entry_t        (way_vec_t),
        .NUM_SET        (NUM_SET)
    )
    i_history_array
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .write_en       (write_en),
        .write_set_addr (write_set_addr),
        .write_data     (write_history),
        .read_en        (read_en),
        .read_set_addr  (read_set_addr),
        .read_data      (read_history)
    );

endmodule

//--- verilog/cache_way_manager.sv
module cache_way_manager
    import cache_pkg::*;
#(
    parameter int NUM_WAY   = cache_pkg::NUM_WAY,
    parameter int NUM_SET   = cache_pkg::NUM_SET,
    parameter int TAG_WIDTH = cache_pkg::TAG_WIDTH
)
(
    input  logic           clk_in,
    input  logic           reset_in,

    input  logic           access_valid,
    input  access_req_t    access,

    output logic           result_valid,
    output access_result_t result
);

    way_vec_t  valid_ways;
    way_vec_t  used_way;
    way_vec_t  victim_way;
    logic      stage_valid;
    set_addr_t stage_set;

    // Both arrays are read with the incoming access, so they stay aligned.
    tag_lookup
    #(
        .NUM_WAY      (NUM_WAY),
        .NUM_SET      (NUM_SET),
        .TAG_WIDTH    (TAG_WIDTH)
    )
    i_tag_lookup
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .access_valid (access_valid),
        .access       (access),
        .victim_way   (victim_way),
        .valid_ways   (valid_ways),
        .used_way     (used_way),
        .stage_valid  (stage_valid),
        .stage_set    (stage_set),
        .result_valid (result_valid),
        .result       (result)
    );

    replacer
    #(
        .NUM_WAY        (NUM_WAY),
        .NUM_SET        (NUM_SET)
    )
    i_replacer
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .read_en        (access_valid),
        .read_set_addr  (access.set),
        .write_en       (stage_valid),
        .write_set_addr (stage_set),
        .valid_ways     (valid_ways),
        .used_way       (used_way),
        .victim_way     (victim_way)
    );

endmodule

//--- bench/way_checker.sv
module way_checker
    import cache_pkg::*;
#(
    parameter int NUM_WAY = cache_pkg::NUM_WAY,
    parameter int NUM_SET = cache_pkg::NUM_SET
)
(
    input  logic           clk_in,
    input  logic           reset_in,
    input  logic           access_valid,
    input  access_req_t    access,
    input  logic           result_valid,
    input  access_result_t result,
    output int             error_count
);

    timeunit 1ns;
    timeprecision 1ns;

    tag_t           model_tags [NUM_SET][NUM_WAY];
    way_vec_t       model_valid [NUM_SET];
    way_vec_t       model_used [NUM_SET];
    access_result_t expected;
    logic           expect_valid = 1'b0;
    int             tests = 0;
    int             checks = 0;
    int             test_checks = 0;
    int             test_errors = 0;
    int             hits = 0;
    int             misses = 0;
    int             evictions = 0;

    initial error_count = 0;

    task automatic compare_value(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        test_checks++;
        if (got !== want)
        begin
            $display("ERROR %s: expected %h, got %h at %0t ns", name, want, got, $time);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < NUM_SET; s++)
        begin
            model_valid[s] = '0;
            model_used[s]  = '0;
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model of one access: lookup, NRU victim, fill, history.
    // ----------------------------------------------------------------------
    task automatic model_access(input access_req_t req, output access_result_t res);
        way_vec_t hit_vec;
        way_vec_t victim;
        way_vec_t merged;
        logic     found;
        hit_vec = '0;
        victim  = '0;
        found   = 1'b0;
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (model_valid[req.set][w] && model_tags[req.set][w] == req.tag)
            begin
                hit_vec[w] = 1'b1;
            end
        end
        if (hit_vec != '0)
        begin
            hits++;
            res = '{hit: 1'b1, way: hit_vec};
        end
        else
        begin
            misses++;
            for (int w = 0; w < NUM_WAY; w++)
            begin
                if (!found && !model_valid[req.set][w])
                begin
                    victim[w] = 1'b1;
                    found     = 1'b1;
                end
            end
            if (!found)
            begin
                evictions++;                            // Set is full.
            end
            for (int w = 0; w < NUM_WAY; w++)
            begin
                if (!found && !model_used[req.set][w])
                begin
                    victim[w] = 1'b1;
                    found     = 1'b1;
                end
            end
            if (!found)
            begin
                victim = way_vec_t'(1);
            end
            for (int w = 0; w < NUM_WAY; w++)
            begin
                if (victim[w])
                begin
                    model_tags[req.set][w]  = req.tag;
                    model_valid[req.set][w] = 1'b1;
                end
            end
            res = '{hit: 1'b0, way: victim};
        end
        merged = model_used[req.set] | res.way;
        model_used[req.set] = (merged == '1) ? res.way : merged;   // All used, start over.
    endtask

    // Inputs and outputs are both settled at the falling edge.
    always @(negedge clk_in)
    begin
        if (reset_in)
        begin
            clear_model();
            expect_valid = 1'b0;
            compare_value("result_valid", 32'(1'b0), 32'(result_valid));
        end
        else
        begin
            compare_value("result_valid", 32'(expect_valid), 32'(result_valid));
            if (expect_valid)
            begin
                compare_value("result.hit", 32'(expected.hit), 32'(result.hit));
                compare_value("result.way", 32'(expected.way), 32'(result.way));
            end
            if (access_valid)
            begin
                model_access(access, expected);
            end
            expect_valid = access_valid;
        end
    end

    task automatic report_test(input string name);
        tests++;
        checks += test_checks;
        $display("%-20s %-6s %0d checks, %0d hits, %0d misses, %0d evictions, %0d errors",
                 name, (test_errors == 0) ? "ok" : "FAILED", test_checks, hits, misses,
                 evictions, test_errors);
        test_checks = 0;
        test_errors = 0;
        hits        = 0;
        misses      = 0;
        evictions   = 0;
    endtask

    task automatic report_totals();
        $display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, error_count);
    endtask

endmodule

//--- bench/cache_way_manager_properties.sv
module cache_way_manager_properties
    import cache_pkg::*;
(
    input logic           clk_in,
    input logic           reset_in,
    input logic           access_valid,
    input logic           result_valid,
    input access_result_t result
);

    timeunit 1ns;
    timeprecision 1ns;

    int failure_count = 0;

    a_quiet_after_reset: assert property (@(posedge clk_in) reset_in |=> !result_valid)
    else
    begin
        failure_count++;
        $error("result_valid is high in the cycle after reset");
    end

    // One result per access, one cycle later.
    a_result_follows: assert property (@(posedge clk_in) disable iff (reset_in)
        access_valid |=> result_valid)
    else
    begin
        failure_count++;
        $error("an access produced no result one cycle later");
    end

    a_no_stray_result: assert property (@(posedge clk_in) disable iff (reset_in)
        !access_valid |=> !result_valid)
    else
    begin
        failure_count++;
        $error("a result appeared without an access");
    end

    a_way_one_hot: assert property (@(posedge clk_in) disable iff (reset_in)
        result_valid |-> $onehot(result.way))
    else
    begin
        failure_count++;
        $error("result way is not one-hot");
    end

endmodule

bind cache_way_manager cache_way_manager_properties i_properties
(
    .clk_in       (clk_in),
    .reset_in     (reset_in),
    .access_valid (access_valid),
    .result_valid (result_valid),
    .result       (result)
);

//--- bench/cache_way_manager_tb.sv
module cache_way_manager_tb
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_WAY        = 4;
    localparam int NUM_SET        = 16;
    localparam int TAG_WIDTH      = 8;
    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_CYCLES  = 800;
    localparam int PAIR_COUNT     = 150;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_SET * NUM_WAY + RANDOM_CYCLES
                                    + 2 * PAIR_COUNT + 100;

    logic           clk_in;
    logic           reset_in;
    logic           access_valid;
    access_req_t    access;
    logic           result_valid;
    access_result_t result;
    int             error_count;
    logic [31:0]    lfsr;

    cache_way_manager
    #(
        .NUM_WAY      (NUM_WAY),
        .NUM_SET      (NUM_SET),
        .TAG_WIDTH    (TAG_WIDTH)
    )
    i_cache_way_manager
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .access_valid (access_valid),
        .access       (access),
        .result_valid (result_valid),
        .result       (result)
    );

    way_checker
    #(
        .NUM_WAY      (NUM_WAY),
        .NUM_SET      (NUM_SET)
    )
    i_way_checker
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .access_valid (access_valid),
        .access       (access),
        .result_valid (result_valid),
        .result       (result),
        .error_count  (error_count)
    );

    initial
    begin
        clk_in = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk_in = ~clk_in;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};   // x^32+x^22+x^2+x+1.
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic issue_access(input logic valid, input int set, input int tag);
        @(posedge clk_in);
        #DRIVE_DELAY;
        access_valid = valid;
        access.set   = set_addr_t'(set);
        access.tag   = tag_t'(tag);
    endtask

    task automatic end_test(input string name);
        issue_access(1'b0, 0, 0);
        issue_access(1'b0, 0, 0);                    // Let the last result be checked.
        i_way_checker.report_test(name);
    endtask

    initial
    begin
        logic [31:0] valid_bits;
        logic [31:0] set_bits;
        logic [31:0] tag_bits;
        lfsr         = 32'h5f90_dd80;
        reset_in     = 1'b1;
        access_valid = 1'b0;
        access       = '0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        reset_in = 1'b0;
        repeat (3) issue_access(1'b0, 0, 0);

        // First pass fills ways in order, the second pass must hit everywhere.
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int s = 0; s < NUM_SET; s++)
            begin
                for (int w = 0; w < NUM_WAY; w++)
                begin
                    issue_access(1'b1, s, w * NUM_SET + s + 1);
                end
            end
        end
        end_test("fill_then_hit");

        // Few sets and few tags, so hits, fills and evictions all show up.
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            draw_bits(2, valid_bits);
            draw_bits(2, set_bits);
            draw_bits(3, tag_bits);
            issue_access(valid_bits != 0, set_bits, tag_bits);
        end
        end_test("random_traffic");

        for (int i = 0; i < PAIR_COUNT; i++)
        begin
            draw_bits(4, set_bits);
            draw_bits(4, tag_bits);
            issue_access(1'b1, set_bits, tag_bits + 32'h80);
            issue_access(1'b1, set_bits, tag_bits + 32'h80);   // Hits the line just filled.
        end
        end_test("back_to_back_pairs");

        i_way_checker.report_totals();
        if (i_cache_way_manager.i_properties.failure_count != 0)
        begin
            $display("%0d assertion failures were reported by the properties module.",
                     i_cache_way_manager.i_properties.failure_count);
        end
        if (error_count == 0 && i_cache_way_manager.i_properties.failure_count == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests completed.",
                 TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- list.f
verilog/cache_pkg.sv
verilog/find_first_one_index.sv
verilog/dual_port_lutram.sv
verilog/tag_lookup.sv
verilog/replacer.sv
verilog/cache_way_manager.sv
bench/way_checker.sv
bench/cache_way_manager_properties.sv
bench/cache_way_manager_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := cache_way_manager_tb
FILE_LIST  := list.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/1ns -j 0
VFLAGS     += --Mdir $(BUILD_DIR) --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+1000
PASS_TEXT  := All tests passed

SOURCES    := $(shell grep -v '^+' $(FILE_LIST))
BINARY     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)

run: $(BINARY)
	@out="$$($(BINARY) $(RUN_FLAGS))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
